// ==== src/muldiv_pkg.sv ====
package muldiv_pkg;

    localparam int XLEN        = 32;
    localparam int NUM_LANES   = 2;
    localparam int MUL_LATENCY = 3;

    // Full signed product of two 33-bit extended operands
    localparam int PROD_W = 2 * (XLEN + 1);

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [NUM_LANES-1:0] lane_mask_t;
    typedef logic [7:0]           uuid_t;
    typedef logic [1:0]           wid_t;
    typedef logic [4:0]           reg_idx_t;

    // Bit 2 set marks the divide group
    typedef enum logic [2:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHSU = 3'd2,
        MULHU  = 3'd3,
        DIV    = 3'd4,
        DIVU   = 3'd5,
        REM    = 3'd6,
        REMU   = 3'd7
    } muldiv_op_e;

    typedef struct packed {
        uuid_t                   uuid;
        wid_t                    wid;
        lane_mask_t              tmask;
        reg_idx_t                rd;
        muldiv_op_e              op;
        xlen_t [NUM_LANES-1:0]   rs1;
        xlen_t [NUM_LANES-1:0]   rs2;
    } muldiv_req_t;

    // Request fields that ride along with the data and come back on commit
    typedef struct packed {
        uuid_t      uuid;
        wid_t       wid;
        lane_mask_t tmask;
        reg_idx_t   rd;
    } muldiv_tag_t;

    typedef struct packed {
        uuid_t                   uuid;
        wid_t                    wid;
        lane_mask_t              tmask;
        reg_idx_t                rd;
        xlen_t [NUM_LANES-1:0]   data;
    } muldiv_rsp_t;

endpackage

// ==== src/mul_pipe.sv ====
module mul_pipe import muldiv_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  logic        in_valid,
    output logic        in_ready,
    input  muldiv_req_t req,

    output logic        out_valid,
    input  logic        out_ready,
    output muldiv_rsp_t rsp
);

    typedef struct packed {
        muldiv_tag_t                      tag;
        logic                             is_hi;
        logic [NUM_LANES-1:0][PROD_W-1:0] prod;
    } stage_t;

    logic                             sign_a;
    logic                             sign_b;
    logic [NUM_LANES-1:0][PROD_W-1:0] prod_in;
    stage_t                           stage_in;
    stage_t                           stage_q [MUL_LATENCY];
    logic [MUL_LATENCY-1:0]           vld_q;
    xlen_t [NUM_LANES-1:0]            result;

    // The whole pipe advances together and freezes only on a blocked output
    assign in_ready  = out_ready || !out_valid;
    assign out_valid = vld_q[MUL_LATENCY-1];

    assign sign_a = req.op inside {MULH, MULHSU};
    assign sign_b = (req.op == MULH);

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        logic signed [XLEN:0] a_ext;
        logic signed [XLEN:0] b_ext;

        assign a_ext      = {sign_a && req.rs1[i][XLEN-1], req.rs1[i]};
        assign b_ext      = {sign_b && req.rs2[i][XLEN-1], req.rs2[i]};
        assign prod_in[i] = a_ext * b_ext;

        assign result[i] = stage_q[MUL_LATENCY-1].is_hi ?
                           stage_q[MUL_LATENCY-1].prod[i][2*XLEN-1:XLEN] :
                           stage_q[MUL_LATENCY-1].prod[i][XLEN-1:0];
    end

    always_comb begin
        stage_in.tag   = '{uuid: req.uuid, wid: req.wid, tmask: req.tmask, rd: req.rd};
        stage_in.is_hi = (req.op != MUL);
        stage_in.prod  = prod_in;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else if (in_ready) begin
            vld_q <= {vld_q[MUL_LATENCY-2:0], in_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready) begin
            stage_q[0] <= stage_in;
            for (int s = 1; s < MUL_LATENCY; s++) begin
                stage_q[s] <= stage_q[s-1];
            end
        end
    end

    always_comb begin
        rsp.uuid  = stage_q[MUL_LATENCY-1].tag.uuid;
        rsp.wid   = stage_q[MUL_LATENCY-1].tag.wid;
        rsp.tmask = stage_q[MUL_LATENCY-1].tag.tmask;
        rsp.rd    = stage_q[MUL_LATENCY-1].tag.rd;
        rsp.data  = result;
    end

    // A stalled result stays on the port unchanged until it is taken
    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(rsp));

endmodule

// ==== src/div_serial.sv ====
module div_serial import muldiv_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  logic        in_valid,
    output logic        in_ready,
    input  muldiv_req_t req,

    output logic        out_valid,
    input  logic        out_ready,
    output muldiv_rsp_t rsp
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } state_e;

    state_e                state_q;
    logic [4:0]            cnt_q;
    muldiv_tag_t           tag_q;
    logic                  is_rem_q;
    xlen_t [NUM_LANES-1:0] rem_q;
    xlen_t [NUM_LANES-1:0] quo_q;
    xlen_t [NUM_LANES-1:0] dvs_q;
    logic [NUM_LANES-1:0]  neg_quo_q;
    logic [NUM_LANES-1:0]  neg_rem_q;

    logic                  op_signed;
    logic                  accept;
    xlen_t [NUM_LANES-1:0] abs_a;
    xlen_t [NUM_LANES-1:0] abs_b;
    logic [NUM_LANES-1:0]  neg_quo_in;
    logic [NUM_LANES-1:0]  neg_rem_in;
    xlen_t [NUM_LANES-1:0] rem_nxt;
    xlen_t [NUM_LANES-1:0] quo_nxt;
    xlen_t [NUM_LANES-1:0] result;

    assign in_ready  = (state_q == IDLE);
    assign out_valid = (state_q == DONE);
    assign accept    = in_valid && in_ready;
    assign op_signed = req.op inside {DIV, REM};

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        logic            a_neg;
        logic            b_neg;
        logic [XLEN:0]   partial;
        logic [XLEN:0]   diff;
        xlen_t           quo_fix;
        xlen_t           rem_fix;

        assign a_neg    = op_signed && req.rs1[i][XLEN-1];
        assign b_neg    = op_signed && req.rs2[i][XLEN-1];
        assign abs_a[i] = a_neg ? -req.rs1[i] : req.rs1[i];
        assign abs_b[i] = b_neg ? -req.rs2[i] : req.rs2[i];

        // A zero divisor must leave the all-ones quotient unsigned.
        // Overflow needs no special case since |MIN| / 1 already gives MIN and 0
        assign neg_quo_in[i] = (a_neg ^ b_neg) && (req.rs2[i] != '0);
        assign neg_rem_in[i] = a_neg;

        // One restoring step, shifting the next dividend bit in from the quotient
        assign partial    = {rem_q[i], quo_q[i][XLEN-1]};
        assign diff       = partial - {1'b0, dvs_q[i]};
        assign rem_nxt[i] = diff[XLEN] ? partial[XLEN-1:0] : diff[XLEN-1:0];
        assign quo_nxt[i] = {quo_q[i][XLEN-2:0], !diff[XLEN]};

        assign quo_fix   = neg_quo_q[i] ? -quo_q[i] : quo_q[i];
        assign rem_fix   = neg_rem_q[i] ? -rem_q[i] : rem_q[i];
        assign result[i] = is_rem_q ? rem_fix : quo_fix;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (in_valid) begin
                        state_q <= RUN;
                    end
                    cnt_q <= '0;
                end
                RUN: begin
                    cnt_q <= cnt_q + 5'd1;
                    if (cnt_q == 5'd31) begin
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    if (out_ready) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tag_q     <= '{uuid: req.uuid, wid: req.wid, tmask: req.tmask, rd: req.rd};
            is_rem_q  <= req.op inside {REM, REMU};
            rem_q     <= '0;
            quo_q     <= abs_a;
            dvs_q     <= abs_b;
            neg_quo_q <= neg_quo_in;
            neg_rem_q <= neg_rem_in;
        end else if (state_q == RUN) begin
            rem_q <= rem_nxt;
            quo_q <= quo_nxt;
        end
    end

    always_comb begin
        rsp.uuid  = tag_q.uuid;
        rsp.wid   = tag_q.wid;
        rsp.tmask = tag_q.tmask;
        rsp.rd    = tag_q.rd;
        rsp.data  = result;
    end

    // A result appears exactly 33 cycles after its request is taken
    a_result_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(out_valid) |-> $past(accept, 33));

    a_cnt_range: assert property (@(posedge clk) disable iff (rst)
        (state_q != RUN) |-> (cnt_q == '0));

endmodule

// ==== src/commit_arb.sv ====
module commit_arb import muldiv_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  logic        mul_valid,
    output logic        mul_ready,
    input  muldiv_rsp_t mul_rsp,

    input  logic        div_valid,
    output logic        div_ready,
    input  muldiv_rsp_t div_rsp,

    output logic        rsp_valid,
    input  logic        rsp_ready,
    output muldiv_rsp_t rsp
);

    logic        last_div_q;
    logic        out_vld_q;
    muldiv_rsp_t out_q;
    logic        load;
    logic        grant_mul;
    logic        grant_div;

    // Register can refill in the cycle it drains
    assign load = !out_vld_q || rsp_ready;

    always_comb begin
        grant_mul = 1'b0;
        grant_div = 1'b0;
        if (load) begin
            if (mul_valid && div_valid) begin
                // Both waiting, so the loser of the last round goes first
                grant_div = !last_div_q;
                grant_mul = last_div_q;
            end else begin
                grant_mul = mul_valid;
                grant_div = div_valid;
            end
        end
    end

    assign mul_ready = grant_mul;
    assign div_ready = grant_div;
    assign rsp_valid = out_vld_q;
    assign rsp       = out_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_vld_q  <= 1'b0;
            last_div_q <= 1'b0;
        end else begin
            if (load) begin
                out_vld_q <= grant_mul || grant_div;
            end
            if (grant_mul || grant_div) begin
                last_div_q <= grant_div;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_mul) begin
            out_q <= mul_rsp;
        end else if (grant_div) begin
            out_q <= div_rsp;
        end
    end

    a_one_grant: assert property (@(posedge clk) disable iff (rst)
        !(mul_ready && div_ready));

endmodule

// ==== src/muldiv_unit.sv ====
module muldiv_unit import muldiv_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  logic        req_valid,
    output logic        req_ready,
    input  muldiv_req_t req,

    output logic        rsp_valid,
    input  logic        rsp_ready,
    output muldiv_rsp_t rsp
);

    logic        is_div;
    logic        mul_in_valid;
    logic        mul_in_ready;
    logic        div_in_valid;
    logic        div_in_ready;

    logic        mul_out_valid;
    logic        mul_out_ready;
    muldiv_rsp_t mul_rsp;
    logic        div_out_valid;
    logic        div_out_ready;
    muldiv_rsp_t div_rsp;

    assign is_div = req.op inside {DIV, DIVU, REM, REMU};

    assign mul_in_valid = req_valid && !is_div;
    assign div_in_valid = req_valid && is_div;
    assign req_ready    = is_div ? div_in_ready : mul_in_ready;

    mul_pipe mul_pipe0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (mul_in_valid),
        .in_ready  (mul_in_ready),
        .req       (req),
        .out_valid (mul_out_valid),
        .out_ready (mul_out_ready),
        .rsp       (mul_rsp)
    );

    div_serial div_serial0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (div_in_valid),
        .in_ready  (div_in_ready),
        .req       (req),
        .out_valid (div_out_valid),
        .out_ready (div_out_ready),
        .rsp       (div_rsp)
    );

    commit_arb commit_arb0 (
        .clk       (clk),
        .rst       (rst),
        .mul_valid (mul_out_valid),
        .mul_ready (mul_out_ready),
        .mul_rsp   (mul_rsp),
        .div_valid (div_out_valid),
        .div_ready (div_out_ready),
        .div_rsp   (div_rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

endmodule

// ==== verif/muldiv_tests.svh ====
`ifndef MULDIV_TESTS_SVH
`define MULDIV_TESTS_SVH

localparam int MUL_PER_OP  = 13;
localparam int DIV_PER_OP  = 8;
localparam int STREAM_LEN  = 16;
localparam int BP_LEN      = 24;
localparam int MIXED_MAX   = 60;
localparam int DIV_LATENCY = 34;
localparam int TOTAL_REQS  = 4 * MUL_PER_OP + 4 * DIV_PER_OP + STREAM_LEN + BP_LEN
                             + MIXED_MAX + 1;

task automatic reset_values();
    int err_start;
    err_start = errors;
    check_bit("rsp_valid", rsp_valid, 1'b0);
    check_bit("req_ready", req_ready, 1'b1);
    // An idle divide request shows whether the divider also left reset idle
    req.op = DIV;
    @(negedge clk);
    check_bit("req_ready divide", req_ready, 1'b1);
    finish_test("reset", err_start);
endtask

task automatic multiply_ops();
    muldiv_op_e            ops [4] = '{MUL, MULH, MULHSU, MULHU};
    xlen_t                 edges [3] = '{32'h0, 32'hffff_ffff, 32'h8000_0000};
    xlen_t [NUM_LANES-1:0] a;
    xlen_t [NUM_LANES-1:0] b;
    uuid_t                 id;
    int                    err_start;
    err_start = errors;
    foreach (ops[o]) begin
        for (int k = 0; k < MUL_PER_OP; k++) begin
            // Every pairing of the edge values first, then random words
            if (k < 9) begin
                a = {edges[k % 3], edges[k / 3]};
                b = {edges[k / 3], edges[k % 3]};
            end else begin
                a = {rand_bits(32), rand_bits(32)};
                b = {rand_bits(32), rand_bits(32)};
            end
            issue(ops[o], a, b, id);
            wait_drain(20);
            commit_latency(id, MUL_LATENCY + 1);
        end
    end
    finish_test("multiply", err_start);
endtask

task automatic divide_ops();
    muldiv_op_e            ops [4] = '{DIV, DIVU, REM, REMU};
    xlen_t [NUM_LANES-1:0] a;
    xlen_t [NUM_LANES-1:0] b;
    uuid_t                 id;
    int                    err_start;
    err_start = errors;
    foreach (ops[o]) begin
        for (int k = 0; k < DIV_PER_OP; k++) begin
            a = {rand_bits(32), rand_bits(32)};
            if (k == DIV_PER_OP - 2) begin
                b = '0;
            end else if (k == DIV_PER_OP - 1) begin
                a = {2{32'h8000_0000}};
                b = '1;
            end else begin
                // Shifted divisors give quotients of many sizes
                b = {rand_bits(32) >> rand_bits(5), rand_bits(32) >> rand_bits(5)};
            end
            issue(ops[o], a, b, id);
            wait_drain(60);
            commit_latency(id, DIV_LATENCY);
        end
    end
    finish_test("divide", err_start);
endtask

task automatic multiply_stream();
    uuid_t id;
    int    c0;
    int    err_start;
    err_start = errors;
    c0 = cycle;
    for (int k = 0; k < STREAM_LEN; k++) begin
        issue(muldiv_op_e'(3'(rand_bits(2))), {rand_bits(32), rand_bits(32)},
              {rand_bits(32), rand_bits(32)}, id);
    end
    check_count("stream accept cycles", cycle - c0, STREAM_LEN);
    wait_drain(40);
    finish_test("multiply stream", err_start);
endtask

task automatic backpressure_mix();
    uuid_t id;
    logic  done;
    int    err_start;
    err_start = errors;
    done = 1'b0;
    fork
        begin
            for (int k = 0; k < BP_LEN; k++) begin
                issue(muldiv_op_e'(3'(rand_bits(3))), {rand_bits(32), rand_bits(32)},
                      {rand_bits(32) >> rand_bits(4), rand_bits(32)}, id);
            end
            done = 1'b1;
        end
        begin
            while (!done) begin
                rsp_ready = 1'b0;
                repeat (int'(rand_bits(3)) + 1) @(negedge clk);
                rsp_ready = 1'b1;
                repeat (int'(rand_bits(2)) + 1) @(negedge clk);
            end
            rsp_ready = 1'b1;
        end
    join
    wait_drain(BP_LEN * 40);
    finish_test("backpressure", err_start);
endtask

task automatic mixed_traffic();
    uuid_t div_id;
    uuid_t id;
    int    n;
    int    err_start;
    err_start = errors;
    issue(DIV, {rand_bits(32), rand_bits(32)}, {rand_bits(16), rand_bits(16)}, div_id);
    n = 0;
    while (exp_q.exists(div_id) && n < MIXED_MAX) begin
        issue(muldiv_op_e'(3'(rand_bits(2))), {rand_bits(32), rand_bits(32)},
              {rand_bits(32), rand_bits(32)}, id);
        n++;
    end
    // The multiplier keeps taking work while the divider runs its 32 steps
    if (n < 32) begin
        $display("Only %0d multiplies were accepted while divide uuid %h ran", n, div_id);
        errors++;
    end
    wait_drain(60);
    if (lat_q.exists(div_id) && lat_q[div_id] > 40) begin
        $display("Divide uuid %h took %0d cycles, more than the bound of 40", div_id,
                 lat_q[div_id]);
        errors++;
    end
    finish_test("mixed traffic", err_start);
endtask

`endif

// ==== verif/muldiv_tb.sv ====
module muldiv_tb import muldiv_pkg::*; ();

    localparam int CLK_PERIOD = 40;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_ready;
    muldiv_req_t req;
    logic        rsp_valid;
    logic        rsp_ready;
    muldiv_rsp_t rsp;

    logic [31:0] lfsr_q = 32'h176ffd4a;
    int          cycle = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    uuid_t       next_uuid = '0;

    // Outstanding requests keyed by uuid, and the issue order of the multiplies
    muldiv_rsp_t exp_q [uuid_t];
    int          acc_cyc_q [uuid_t];
    int          lat_q [uuid_t];
    bit          is_mul_q [uuid_t];
    uuid_t       mul_order_q [$];

    muldiv_unit dut0 (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Galois LFSR stepped once per bit handed out
    function automatic xlen_t rand_bits(input int n);
        xlen_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[XLEN-2:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    function automatic xlen_t model_lane(input muldiv_op_e op, input xlen_t a, input xlen_t b);
        longint sa;
        longint sb;
        longint ua;
        longint ub;
        longint p;
        logic   zero_div;
        logic   ovf;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'h0, a};
        ub = {32'h0, b};
        zero_div = (b == '0);
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        p = '0;
        case (op)
            MUL:    p = ua * ub;
            MULH:   p = (sa * sb) >>> 32;
            MULHSU: p = (sa * ub) >>> 32;
            MULHU:  p = (ua * ub) >> 32;
            DIV:    p = zero_div ? -64'sd1 : (ovf ? sa : sa / sb);
            DIVU:   p = zero_div ? '1 : ua / ub;
            REM:    p = zero_div ? sa : (ovf ? 64'sd0 : sa % sb);
            REMU:   p = zero_div ? ua : ua % ub;
        endcase
        return p[31:0];
    endfunction

    function automatic muldiv_rsp_t model_rsp(input muldiv_req_t r);
        muldiv_rsp_t m;
        m.uuid  = r.uuid;
        m.wid   = r.wid;
        m.tmask = r.tmask;
        m.rd    = r.rd;
        for (int i = 0; i < NUM_LANES; i++) begin
            m.data[i] = model_lane(r.op, r.rs1[i], r.rs2[i]);
        end
        return m;
    endfunction

    task automatic show_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("Mismatch %s: got %h expected %h", name, got, exp);
        errors++;
    endtask

    task automatic check_rsp(input muldiv_rsp_t got, input muldiv_rsp_t exp);
        checks++;
        if (got.uuid !== exp.uuid) show_mismatch("uuid", 32'(got.uuid), 32'(exp.uuid));
        if (got.wid !== exp.wid) show_mismatch("wid", 32'(got.wid), 32'(exp.wid));
        if (got.tmask !== exp.tmask) show_mismatch("tmask", 32'(got.tmask), 32'(exp.tmask));
        if (got.rd !== exp.rd) show_mismatch("rd", 32'(got.rd), 32'(exp.rd));
        // Inactive lanes carry no meaningful data
        for (int i = 0; i < NUM_LANES; i++) begin
            if (exp.tmask[i] && got.data[i] !== exp.data[i]) begin
                show_mismatch($sformatf("data[%0d] uuid %h", i, exp.uuid), got.data[i],
                              exp.data[i]);
            end
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) show_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) show_mismatch(name, got, exp);
    endtask

    task automatic collect(input muldiv_rsp_t got);
        uuid_t first;
        if (!exp_q.exists(got.uuid)) begin
            $display("Commit carries uuid %h, which has no outstanding request", got.uuid);
            errors++;
        end else begin
            if (is_mul_q[got.uuid]) begin
                first = mul_order_q.pop_front();
                if (first != got.uuid) begin
                    $display("Multiply uuid %h committed ahead of uuid %h", got.uuid, first);
                    errors++;
                end
            end
            check_rsp(got, exp_q[got.uuid]);
            lat_q[got.uuid] = cycle - acc_cyc_q[got.uuid];
            exp_q.delete(got.uuid);
        end
    endtask

    // Handshakes are sampled at the rising edge, before any register updates
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!rst && req_valid && req_ready) begin
            acc_cyc_q[req.uuid] = cycle;
            exp_q[req.uuid]     = model_rsp(req);
            is_mul_q[req.uuid]  = !(req.op inside {DIV, DIVU, REM, REMU});
            if (is_mul_q[req.uuid]) mul_order_q.push_back(req.uuid);
        end
        if (!rst && rsp_valid && rsp_ready) begin
            collect(rsp);
        end
    end

    // Starts on a falling edge and returns on the falling edge after the accept
    task automatic issue(input muldiv_op_e op, input xlen_t [NUM_LANES-1:0] a,
                         input xlen_t [NUM_LANES-1:0] b, output uuid_t id);
        id        = next_uuid;
        req.uuid  = next_uuid;
        req.wid   = wid_t'(rand_bits(2));
        req.tmask = lane_mask_t'(rand_bits(NUM_LANES));
        if (req.tmask == '0) req.tmask = '1;
        req.rd    = reg_idx_t'(rand_bits(5));
        req.op    = op;
        req.rs1   = a;
        req.rs2   = b;
        req_valid = 1'b1;
        next_uuid++;
        @(posedge clk);
        while (!req_ready) @(posedge clk);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_drain(input int max_cycles);
        int n;
        n = 0;
        while (exp_q.num() != 0 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.num() != 0) begin
            $display("%0d responses never committed within %0d cycles", exp_q.num(),
                     max_cycles);
            errors++;
        end
    endtask

    task automatic commit_latency(input uuid_t id, input int exp);
        if (lat_q.exists(id)) check_count($sformatf("latency uuid %h", id), lat_q[id], exp);
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) $display("%s: ok", name);
        else $display("%s: %0d errors", name, errors - err_start);
    endtask

    `include "muldiv_tests.svh"

    initial begin
        repeat (TOTAL_REQS * 40 + 200) @(posedge clk);
        $display("Watchdog timeout: the run did not finish in %0d cycles",
                 TOTAL_REQS * 40 + 200);
        $display("test failed");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_values();
        multiply_ops();
        divide_ops();
        multiply_stream();
        backpressure_mix();
        mixed_traffic();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== muldiv.f ====
+incdir+verif
src/muldiv_pkg.sv
src/mul_pipe.sv
src/div_serial.sv
src/commit_arb.sv
src/muldiv_unit.sv
verif/muldiv_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := muldiv_tb
FILELIST   := muldiv.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := test failed
PASS_MSG   := test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
